/* sources.f */
+incdir+verilog
verilog/lane_pkg.sv
verilog/lane_alu.sv
verilog/lane_mul.sv
verilog/lane_regfile.sv
verilog/lane_top.sv
dv/lane_sva.sv
dv/lane_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
  --top-module lane_tb -o lane_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/lane_sim > sim.log 2>&1 ; cat sim.log
grep -q 'All tests passed!' sim.log && echo PASS || { echo FAIL; exit 1; }

/* dv/lane_tb.sv */
/*
 * Lane testbench
 *   - clock, reset and random issue and load stimulus
 *   - register mirror with a two-stage pending-write model
 *   - writeback, grant and read port checks, watchdog
 */

`timescale 1ns/1ps

module lane_tb;

  import lane_pkg::*;

  localparam int RST_CYCLES  = 5;
  localparam int PH_LOAD     = 0;
  localparam int PH_ALU      = 1;
  localparam int PH_MUL      = 2;
  localparam int PH_DEP      = 3;
  localparam int PH_MIX      = 4;
  localparam int PH_DRAIN    = 5;
  localparam int NUM_CYCLES  = 16 + 120 + 120 + 120 + 600 + 8;
  localparam int MARGIN      = 100;
  localparam int TIMEOUT_NS  = (RST_CYCLES + NUM_CYCLES + 2 * 8 + MARGIN) * 10;

  logic       clk_i, rst_ni;
  logic       issue_valid, ld_req, ld_gnt, wb_valid;
  lane_op_e   issue_op;
  sew_e       issue_sew;
  vreg_addr_t issue_vs1, issue_vs2, issue_vd, ld_vd, rd_addr, wb_vd;
  elem_word_u ld_data, rd_data, wb_data;

  // Reference model state
  logic [63:0] mirror [8];
  logic        p1_valid, p2_valid, ld_pending;
  logic [2:0]  p1_vd, p2_vd, last_vd;
  logic [63:0] p1_data, p2_data;
  integer      seed = 32'hddb1d40f;
  int          errors;

  lane_top dut_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_valid_i (issue_valid),
    .issue_op_i    (issue_op),
    .issue_sew_i   (issue_sew),
    .issue_vs1_i   (issue_vs1),
    .issue_vs2_i   (issue_vs2),
    .issue_vd_i    (issue_vd),
    .ld_req_i      (ld_req),
    .ld_vd_i       (ld_vd),
    .ld_data_i     (ld_data),
    .ld_gnt_o      (ld_gnt),
    .rd_addr_i     (rd_addr),
    .rd_data_o     (rd_data),
    .wb_valid_o    (wb_valid),
    .wb_vd_o       (wb_vd),
    .wb_data_o     (wb_data)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Reference model helpers
  //////////////////////////////////////////////////

  // Low 64 bits of the operation on full words
  function automatic logic [63:0] apply_op(lane_op_e op, logic [63:0] a, logic [63:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      OP_MUL:  return a * b;
      default: return 64'h0;
    endcase
  endfunction

  // Low 32 bits of each half depend only on that half's operands
  function automatic logic [63:0] expect_result(lane_op_e op, sew_e sew,
                                                logic [63:0] a, logic [63:0] b);
    logic [63:0] lo, hi;
    lo = apply_op(op, {32'h0, a[31:0]}, {32'h0, b[31:0]});
    hi = apply_op(op, {32'h0, a[63:32]}, {32'h0, b[63:32]});
    return (sew == SEW64) ? apply_op(op, a, b) : {hi[31:0], lo[31:0]};
  endfunction

  function automatic lane_op_e pick_op(int phase, logic [2:0] r);
    case (phase)
      PH_ALU:  return lane_op_e'({1'b0, r[1:0]});
      PH_MUL:  return OP_MUL;
      default: return lane_op_e'(r[2] ? 3'd4 : {1'b0, r[1:0]});
    endcase
  endfunction

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    errors++;
    $display("** Error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
  endtask

  //////////////////////////////////////////////////
  // One clock cycle of stimulus and checks
  //////////////////////////////////////////////////

  task automatic run_cycle(int phase, int n);
    logic [31:0] r, hi, lo;
    logic        granted;
    @(negedge clk_i);
    if (wb_valid !== p2_valid) report_mismatch("wb_valid_o", 64'(wb_valid), 64'(p2_valid));
    if (p2_valid && wb_vd !== p2_vd) report_mismatch("wb_vd_o", 64'(wb_vd), 64'(p2_vd));
    if (p2_valid && wb_data.d !== p2_data) report_mismatch("wb_data_o", wb_data.d, p2_data);
    r  = $random(seed);
    hi = $random(seed);
    lo = $random(seed);
    issue_valid = (phase != PH_LOAD) && (phase != PH_DRAIN) && (r[1:0] != 2'd0);
    issue_op    = pick_op(phase, r[10:8]);
    issue_sew   = sew_e'(r[2]);
    issue_vs1   = (phase == PH_DEP) ? last_vd : r[13:11];
    issue_vs2   = r[16:14];
    issue_vd    = r[19:17];
    rd_addr     = r[22:20];
    // A new load starts only once the previous one was granted
    if (!ld_pending && phase != PH_DRAIN && (phase == PH_LOAD || r[24:23] == 2'd0)) begin
      ld_pending = 1'b1;
      ld_vd      = (phase == PH_LOAD) ? n[2:0] : r[27:25];
      ld_data.d  = {hi, lo};
    end
    ld_req = ld_pending;
    #1;
    granted = ld_req && !p2_valid;
    if (ld_gnt !== granted) report_mismatch("ld_gnt_o", 64'(ld_gnt), 64'(granted));
    if (rd_data.d !== mirror[rd_addr]) report_mismatch("rd_data_o", rd_data.d, mirror[rd_addr]);
    // Model of the coming rising edge
    if (p2_valid) begin
      mirror[p2_vd] = p2_data;
    end else if (granted) begin
      mirror[ld_vd] = ld_data.d;
      ld_pending    = 1'b0;
    end
    p2_valid = p1_valid;
    p2_vd    = p1_vd;
    p2_data  = p1_data;
    p1_valid = issue_valid;
    p1_vd    = issue_vd;
    p1_data  = expect_result(issue_op, issue_sew, mirror_old(issue_vs1), mirror_old(issue_vs2));
    if (issue_valid) last_vd = issue_vd;
  endtask

  // Snapshot of operands taken before the model write above
  logic [63:0] opnd_snap [8];
  function automatic logic [63:0] mirror_old(logic [2:0] addr);
    return opnd_snap[addr];
  endfunction

  always @(negedge clk_i) begin
    opnd_snap <= mirror;
  end

  task automatic run_phase(int phase, int count);
    for (int n = 0; n < count; n++) begin
      run_cycle(phase, n);
    end
  endtask

  task automatic sweep_registers();
    for (int i = 0; i < 8; i++) begin
      @(negedge clk_i);
      rd_addr = 3'(i);
      #1;
      if (rd_data.d !== mirror[i]) report_mismatch("rd_data_o", rd_data.d, mirror[i]);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    errors      = 0;
    rst_ni      = 1'b0;
    issue_valid = 1'b0;
    issue_op    = OP_ADD;
    issue_sew   = SEW64;
    issue_vs1   = '0;
    issue_vs2   = '0;
    issue_vd    = '0;
    ld_req      = 1'b0;
    ld_vd       = '0;
    ld_data     = '0;
    rd_addr     = '0;
    foreach (mirror[i]) mirror[i] = '0;
    p1_valid    = 1'b0;
    p2_valid    = 1'b0;
    p1_vd       = '0;
    p2_vd       = '0;
    p1_data     = '0;
    p2_data     = '0;
    last_vd     = '0;
    ld_pending  = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    if (wb_valid !== 1'b0) report_mismatch("wb_valid_o", 64'(wb_valid), 64'(0));
    sweep_registers();
    run_phase(PH_LOAD, 16);
    run_phase(PH_ALU, 120);
    run_phase(PH_MUL, 120);
    run_phase(PH_DEP, 120);
    run_phase(PH_MIX, 600);
    run_phase(PH_DRAIN, 8);
    sweep_registers();
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before the test sequence finished");
    $display("Test failures found");
    $finish;
  end

endmodule

/* dv/lane_sva.sv */
/*
 * Writeback assertions bound to the lane register file
 *   - at most one unit result per cycle
 *   - load request held until it is granted
 *   - no writeback while reset is asserted
 */

`timescale 1ns/1ps

module lane_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic alu_valid_i,
  input logic mul_valid_i,
  input logic ld_req_i,
  input logic ld_gnt_i,
  input logic wb_valid_i
);

  one_result_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(alu_valid_i && mul_valid_i))
    else $error("ALU and multiplier results valid in the same cycle");

  // A waiting load keeps its request up until the write port frees
  req_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ld_req_i && !ld_gnt_i |=> ld_req_i)
    else $error("Load request dropped before it was granted");

  // Unit pipelines are cleared by reset
  no_wb_in_reset_a: assert property (@(posedge clk_i)
    !rst_ni |-> !wb_valid_i)
    else $error("Writeback valid during reset");

endmodule

bind lane_regfile lane_sva sva_i (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .alu_valid_i (alu_valid_i),
  .mul_valid_i (mul_valid_i),
  .ld_req_i    (ld_req_i),
  .ld_gnt_i    (ld_gnt_o),
  .wb_valid_i  (wb_valid_o)
);

/* verilog/lane_top.sv */
/*
 * Lane top level
 *   - register file with load and observation ports
 *   - integer ALU and multiplier side by side
 */

`timescale 1ns/1ps

module lane_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Issue
  input  logic                  issue_valid_i,
  input  lane_pkg::lane_op_e    issue_op_i,
  input  lane_pkg::sew_e        issue_sew_i,
  input  lane_pkg::vreg_addr_t  issue_vs1_i,
  input  lane_pkg::vreg_addr_t  issue_vs2_i,
  input  lane_pkg::vreg_addr_t  issue_vd_i,
  // Load
  input  logic                  ld_req_i,
  input  lane_pkg::vreg_addr_t  ld_vd_i,
  input  lane_pkg::elem_word_u  ld_data_i,
  output logic                  ld_gnt_o,
  // Observation
  input  lane_pkg::vreg_addr_t  rd_addr_i,
  output lane_pkg::elem_word_u  rd_data_o,
  output logic                  wb_valid_o,
  output lane_pkg::vreg_addr_t  wb_vd_o,
  output lane_pkg::elem_word_u  wb_data_o
);

  import lane_pkg::*;

  elem_word_u rs1_data, rs2_data;
  logic       alu_res_valid, mul_res_valid;
  vreg_addr_t alu_res_vd, mul_res_vd;
  elem_word_u alu_res_data, mul_res_data;

  lane_regfile i_regfile (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rs1_addr_i  (issue_vs1_i),
    .rs2_addr_i  (issue_vs2_i),
    .rs1_data_o  (rs1_data),
    .rs2_data_o  (rs2_data),
    .alu_valid_i (alu_res_valid),
    .alu_vd_i    (alu_res_vd),
    .alu_data_i  (alu_res_data),
    .mul_valid_i (mul_res_valid),
    .mul_vd_i    (mul_res_vd),
    .mul_data_i  (mul_res_data),
    .ld_req_i    (ld_req_i),
    .ld_vd_i     (ld_vd_i),
    .ld_data_i   (ld_data_i),
    .ld_gnt_o    (ld_gnt_o),
    .rd_addr_i   (rd_addr_i),
    .rd_data_o   (rd_data_o),
    .wb_valid_o  (wb_valid_o),
    .wb_vd_o     (wb_vd_o),
    .wb_data_o   (wb_data_o)
  );

  // Both units see every issue and pick their own opcodes
  lane_alu i_alu (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_valid_i (issue_valid_i),
    .issue_op_i    (issue_op_i),
    .issue_sew_i   (issue_sew_i),
    .issue_vd_i    (issue_vd_i),
    .opa_i         (rs1_data),
    .opb_i         (rs2_data),
    .res_valid_o   (alu_res_valid),
    .res_vd_o      (alu_res_vd),
    .res_data_o    (alu_res_data)
  );

  lane_mul i_mul (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_valid_i (issue_valid_i),
    .issue_op_i    (issue_op_i),
    .issue_sew_i   (issue_sew_i),
    .issue_vd_i    (issue_vd_i),
    .opa_i         (rs1_data),
    .opb_i         (rs2_data),
    .res_valid_o   (mul_res_valid),
    .res_vd_o      (mul_res_vd),
    .res_data_o    (mul_res_data)
  );

endmodule

/* verilog/lane_regfile.sv */
/*
 * Lane vector register file
 *   - two combinational operand reads and one observation read
 *   - writeback of the ALU or multiplier result
 *   - load writes granted only in cycles without a unit result
 */

`timescale 1ns/1ps

`include "lane_defs.svh"

module lane_regfile (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Operand reads
  input  lane_pkg::vreg_addr_t  rs1_addr_i,
  input  lane_pkg::vreg_addr_t  rs2_addr_i,
  output lane_pkg::elem_word_u  rs1_data_o,
  output lane_pkg::elem_word_u  rs2_data_o,
  // Unit results
  input  logic                  alu_valid_i,
  input  lane_pkg::vreg_addr_t  alu_vd_i,
  input  lane_pkg::elem_word_u  alu_data_i,
  input  logic                  mul_valid_i,
  input  lane_pkg::vreg_addr_t  mul_vd_i,
  input  lane_pkg::elem_word_u  mul_data_i,
  // Load writes
  input  logic                  ld_req_i,
  input  lane_pkg::vreg_addr_t  ld_vd_i,
  input  lane_pkg::elem_word_u  ld_data_i,
  output logic                  ld_gnt_o,
  // Observation
  input  lane_pkg::vreg_addr_t  rd_addr_i,
  output lane_pkg::elem_word_u  rd_data_o,
  output logic                  wb_valid_o,
  output lane_pkg::vreg_addr_t  wb_vd_o,
  output lane_pkg::elem_word_u  wb_data_o
);

  import lane_pkg::*;

  elem_word_u regs_q [`LANE_NR_VREGS];

  //////////////////////////////////////////////////
  // Writeback select
  //////////////////////////////////////////////////

  // Equal unit latency keeps the two valids apart
  assign wb_valid_o = alu_valid_i | mul_valid_i;
  assign wb_vd_o    = alu_valid_i ? alu_vd_i : mul_vd_i;
  assign wb_data_o  = alu_valid_i ? alu_data_i : mul_data_i;

  // Loads wait for a free write port
  assign ld_gnt_o = ld_req_i & ~wb_valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '{default: '0};
    end else if (wb_valid_o) begin
      regs_q[wb_vd_o] <= wb_data_o;
    end else if (ld_gnt_o) begin
      regs_q[ld_vd_i] <= ld_data_i;
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  // No bypass, a read in the write cycle sees the old value
  assign rs1_data_o = regs_q[rs1_addr_i];
  assign rs2_data_o = regs_q[rs2_addr_i];
  assign rd_data_o  = regs_q[rd_addr_i];

endmodule

/* verilog/lane_mul.sv */
/*
 * Two-stage integer multiplier
 *   - low 64 bits of the product at SEW64
 *   - two independent low 32-bit products at SEW32
 */

`timescale 1ns/1ps

`include "lane_defs.svh"

module lane_mul (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  issue_valid_i,
  input  lane_pkg::lane_op_e    issue_op_i,
  input  lane_pkg::sew_e        issue_sew_i,
  input  lane_pkg::vreg_addr_t  issue_vd_i,
  input  lane_pkg::elem_word_u  opa_i,
  input  lane_pkg::elem_word_u  opb_i,
  output logic                  res_valid_o,
  output lane_pkg::vreg_addr_t  res_vd_o,
  output lane_pkg::elem_word_u  res_data_o
);

  import lane_pkg::*;

  logic                     accept;
  logic [`LANE_UNIT_LAT-1:0] valid_q;
  sew_e                     sew_q;
  vreg_addr_t               vd_q, vd2_q;
  elem_word_u               opa_q, opb_q;
  elem_word_u               prod_d, prod_q;

  assign accept = issue_valid_i && (issue_op_i == OP_MUL);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[`LANE_UNIT_LAT-2:0], accept};
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      sew_q <= issue_sew_i;
      vd_q  <= issue_vd_i;
      opa_q <= opa_i;
      opb_q <= opb_i;
    end
    if (valid_q[0]) begin
      vd2_q  <= vd_q;
      prod_q <= prod_d;
    end
  end

  // Product truncated to the element width
  always_comb begin
    prod_d = '0;
    if (sew_q == SEW64) begin
      prod_d.d = opa_q.d * opb_q.d;
    end else begin
      for (int i = 0; i < 2; i++) begin
        prod_d.w[i] = opa_q.w[i] * opb_q.w[i];
      end
    end
  end

  assign res_valid_o = valid_q[`LANE_UNIT_LAT-1];
  assign res_vd_o    = vd2_q;
  assign res_data_o  = prod_q;

endmodule

/* verilog/lane_alu.sv */
/*
 * Two-stage integer ALU
 *   - add, subtract, and, xor
 *   - 64-bit elements or two independent 32-bit elements per word
 */

`timescale 1ns/1ps

`include "lane_defs.svh"

module lane_alu (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  issue_valid_i,
  input  lane_pkg::lane_op_e    issue_op_i,
  input  lane_pkg::sew_e        issue_sew_i,
  input  lane_pkg::vreg_addr_t  issue_vd_i,
  input  lane_pkg::elem_word_u  opa_i,
  input  lane_pkg::elem_word_u  opb_i,
  output logic                  res_valid_o,
  output lane_pkg::vreg_addr_t  res_vd_o,
  output lane_pkg::elem_word_u  res_data_o
);

  import lane_pkg::*;

  logic                     accept;
  logic [`LANE_UNIT_LAT-1:0] valid_q;
  lane_op_e                 op_q;
  sew_e                     sew_q;
  vreg_addr_t               vd_q, vd2_q;
  elem_word_u               opa_q, opb_q;
  elem_word_u               res_d, res_q;

  // Everything except the multiply belongs here
  assign accept = issue_valid_i && (issue_op_i != OP_MUL);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[`LANE_UNIT_LAT-2:0], accept};
    end
  end

  //////////////////////////////////////////////////
  // Operand and result stages
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q  <= issue_op_i;
      sew_q <= issue_sew_i;
      vd_q  <= issue_vd_i;
      opa_q <= opa_i;
      opb_q <= opb_i;
    end
    if (valid_q[0]) begin
      vd2_q <= vd_q;
      res_q <= res_d;
    end
  end

  // Halves are computed separately at SEW32, so no carry crosses bit 32
  always_comb begin
    res_d = '0;
    if (sew_q == SEW64) begin
      case (op_q)
        OP_ADD:  res_d.d = opa_q.d + opb_q.d;
        OP_SUB:  res_d.d = opa_q.d - opb_q.d;
        OP_AND:  res_d.d = opa_q.d & opb_q.d;
        OP_XOR:  res_d.d = opa_q.d ^ opb_q.d;
        default: res_d.d = '0;
      endcase
    end else begin
      for (int i = 0; i < 2; i++) begin
        case (op_q)
          OP_ADD:  res_d.w[i] = opa_q.w[i] + opb_q.w[i];
          OP_SUB:  res_d.w[i] = opa_q.w[i] - opb_q.w[i];
          OP_AND:  res_d.w[i] = opa_q.w[i] & opb_q.w[i];
          OP_XOR:  res_d.w[i] = opa_q.w[i] ^ opb_q.w[i];
          default: res_d.w[i] = '0;
        endcase
      end
    end
  end

  assign res_valid_o = valid_q[`LANE_UNIT_LAT-1];
  assign res_vd_o    = vd2_q;
  assign res_data_o  = res_q;

endmodule

/* verilog/lane_pkg.sv */
/*
 * Lane types
 *   - opcode and element width encodings
 *   - vector register address
 *   - register word seen as one 64-bit or two 32-bit elements
 */

`include "lane_defs.svh"

package lane_pkg;

  //////////////////////////////////////////////////
  // Instruction fields
  //////////////////////////////////////////////////

  // OP_MUL goes to the multiplier, everything else to the ALU
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_XOR,
    OP_MUL
  } lane_op_e;

  typedef enum logic {
    SEW32,
    SEW64
  } sew_e;

  typedef logic [`LANE_VREG_AW-1:0] vreg_addr_t;

  // Element 0 sits in the low half of the word
  typedef union packed {
    logic [`LANE_ELEN-1:0]            d;
    logic [1:0][`LANE_ELEN/2-1:0]     w;
  } elem_word_u;

endpackage

/* verilog/lane_defs.svh */
/*
 * Fixed lane dimensions
 *   - register word and datapath width
 *   - number of vector registers and their address width
 *   - issue-to-writeback latency of the execution units
 */

`ifndef LANE_DEFS_SVH
`define LANE_DEFS_SVH

// Datapath width in bits
`define LANE_ELEN 64

// Vector registers held by the lane
`define LANE_NR_VREGS 8
`define LANE_VREG_AW 3

// Cycles from issue edge to result register, same for ALU and multiplier
`define LANE_UNIT_LAT 2

`endif
